// ==== wb_stage.f ====
+incdir+include
verilog/wb_pkg.sv
verilog/csr_cmd_if.sv
verilog/gpr_file.sv
verilog/csr_file.sv
verilog/commit_ctrl.sv
verilog/wb_stage.sv
verification/clk_gen.sv
verification/wb_stage_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the wb_stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module wb_stage_tb -Mdir obj_dir \
    -f wb_stage.f \
    && sim_out="$(./obj_dir/Vwb_stage_tb 2>&1 || true)" \
    && echo "$sim_out" \
    && grep -qx "Test completed successfully" <<< "$sim_out" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// ==== verification/wb_stage_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "wb_macros.svh"

module wb_stage_tb;

    localparam int period = 40;
    localparam int n_gpr  = 24;
    localparam int n_tick = 12;
    localparam int sweep  = `WB_NREG + 8;  // every gpr, then every csr address
    localparam int test_cycles = 5 + (1 + sweep) + (n_gpr + 3 + sweep) + (3 * 8 + 2 + sweep)
                                 + (15 + sweep) + 8 + (n_tick + 2);
    localparam logic [`WB_XLEN-1:0] mtip = 64'd1 << `WB_MIP_MTIP;

    logic clk;
    logic rst;
    logic commit_valid;
    logic timer_irq;
    wb_pkg::wb_src_e   src;
    wb_pkg::trap_e     trap;
    wb_pkg::redirect_e redirect;
    logic [`WB_REG_AW-1:0] rd, rs1, id_rs1, id_rs2, exe_rs1, exe_rs2, mem_rs2;
    logic [`WB_CSR_AW-1:0] csr_addr, exe_csr;
    logic [`WB_XLEN-1:0]   exe_result, mem_data, imm, zimm, pc;
    logic [`WB_XLEN-1:0]   id_rs1_data, id_rs2_data, exe_rs1_data, exe_rs2_data, mem_rs2_data;
    logic [`WB_XLEN-1:0]   exe_csr_data, mtvec, mepc, mstatus, mie, mip;

    // reference model
    logic [`WB_XLEN-1:0]   m_regs [`WB_NREG];
    logic [`WB_XLEN-1:0]   m_mtvec, m_mepc, m_mcause, m_mstatus, m_mie, m_mip;
    logic [`WB_CSR_AW-1:0] csr_list [8];
    logic [`WB_REG_AW-1:0] last_rd;
    int errors;
    int passed;
    int failed;

    clk_gen #(.period(period)) u_clk (.clk, .rst);

    wb_stage dut (.*);

    function automatic logic [63:0] rand64();
        return {$urandom, $urandom};
    endfunction

    function automatic logic [4:0] rand_reg();
        logic [31:0] r;
        r = $urandom_range(31, 1);
        return r[4:0];
    endfunction

    function automatic logic [63:0] cause_of(input wb_pkg::trap_e t);
        case (t)
            wb_pkg::trap_illegal:        return 64'd2;
            wb_pkg::trap_ebreak:         return 64'd3;
            wb_pkg::trap_load_misalign:  return 64'd4;
            wb_pkg::trap_store_misalign: return 64'd6;
            wb_pkg::trap_ecall:          return 64'd11;
            wb_pkg::trap_timer_irq:      return {1'b1, 63'd7};
            default:                     return 64'd0;
        endcase
    endfunction

    function automatic logic implemented(input logic [11:0] a);
        return a inside {12'h300, 12'h304, 12'h305, 12'h341, 12'h342, 12'h344, 12'hF14};
    endfunction

    function automatic logic [63:0] model_csr(input logic [11:0] a);
        case (a)
            wb_pkg::csr_mstatus: return m_mstatus;
            wb_pkg::csr_mie:     return m_mie;
            wb_pkg::csr_mtvec:   return m_mtvec;
            wb_pkg::csr_mepc:    return m_mepc;
            wb_pkg::csr_mcause:  return m_mcause;
            wb_pkg::csr_mip:     return m_mip;
            default:             return 64'd0;
        endcase
    endfunction

    task automatic swap_model(input logic [11:0] a, input logic [63:0] v);
        case (a)
            wb_pkg::csr_mstatus: m_mstatus = v;
            wb_pkg::csr_mie:     m_mie = v & mtip;
            wb_pkg::csr_mtvec:   m_mtvec = v;
            wb_pkg::csr_mepc:    m_mepc = v;
            wb_pkg::csr_mcause:  m_mcause = v;
            default: ;  // mip follows the pin, mhartid fixed
        endcase
    endtask

    task automatic check_val(input logic [63:0] got, input logic [63:0] exp, input string what);
        if (got !== exp) begin
            errors++;
            $display("MISMATCH at time %0t: %s, got %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic quiet();
        commit_valid = 1'b0;
        src = wb_pkg::src_none;
        trap = wb_pkg::trap_none;
    endtask

    task automatic check_outputs();
        check_val(mtvec, m_mtvec, "mtvec");
        check_val(mepc, m_mepc, "mepc");
        check_val(mstatus, m_mstatus, "mstatus");
        check_val(mie, m_mie, "mie");
        check_val(mip, m_mip, "mip");
        check_val(exe_csr_data, model_csr(exe_csr), $sformatf("csr %h on exe port", exe_csr));
    endtask

    task automatic idle();
        @(negedge clk);
        quiet();
        exe_csr = wb_pkg::csr_mcause;
        #2;
        check_val(64'(redirect), 64'(wb_pkg::redir_none), "redirect while idle");
        check_outputs();
    endtask

    task automatic sweep_state();
        for (int i = 0; i < `WB_NREG; i++) begin
            @(negedge clk);
            quiet();
            id_rs1 = i[4:0];
            id_rs2 = i[4:0];
            exe_rs1 = i[4:0];
            exe_rs2 = i[4:0];
            mem_rs2 = i[4:0];
            #2;
            check_val(id_rs1_data, m_regs[i], $sformatf("x%0d on id_rs1", i));
            check_val(id_rs2_data, m_regs[i], $sformatf("x%0d on id_rs2", i));
            check_val(exe_rs1_data, m_regs[i], $sformatf("x%0d on exe_rs1", i));
            check_val(exe_rs2_data, m_regs[i], $sformatf("x%0d on exe_rs2", i));
            check_val(mem_rs2_data, m_regs[i], $sformatf("x%0d on mem_rs2", i));
        end
        for (int k = 0; k < 8; k++) begin
            @(negedge clk);
            quiet();
            exe_csr = csr_list[k];
            #2;
            check_outputs();
        end
    endtask

    // one committed instruction, checked against the model in its own cycle
    task automatic commit(input wb_pkg::wb_src_e s, input wb_pkg::trap_e t,
                          input logic [4:0] rd_a, input logic [4:0] rs1_a,
                          input logic [11:0] ca, input logic [63:0] val, input logic [63:0] p);
        logic [63:0] ops [4];  // exe, mem, imm, zimm
        logic [63:0] wd;
        logic we;
        wb_pkg::redirect_e exp_redir;
        for (int i = 0; i < 4; i++) begin
            ops[i] = rand64();
        end
        case (s)
            wb_pkg::src_exe, wb_pkg::src_csrrw_exe: ops[0] = val;
            wb_pkg::src_mem:    ops[1] = val;
            wb_pkg::src_imm:    ops[2] = val;
            wb_pkg::src_csrrwi: ops[3] = val;
            default: ;
        endcase
        @(negedge clk);
        commit_valid = 1'b1;
        src = s;
        trap = t;
        rd = rd_a;
        rs1 = rs1_a;
        csr_addr = ca;
        exe_result = ops[0];
        mem_data = ops[1];
        imm = ops[2];
        zimm = ops[3];
        pc = p;
        id_rs1 = rd_a;
        exe_rs1 = last_rd;
        exe_csr = wb_pkg::csr_mcause;
        #2;
        check_outputs();
        check_val(id_rs1_data, m_regs[rd_a], "rd before its write edge");
        check_val(exe_rs1_data, m_regs[last_rd], "previous rd after its write edge");
        exp_redir = wb_pkg::redir_none;
        we = s inside {wb_pkg::src_exe, wb_pkg::src_mem, wb_pkg::src_imm, wb_pkg::src_snpc};
        wd = '0;
        if (t == wb_pkg::trap_mret) begin
            exp_redir = wb_pkg::redir_mepc;
            m_mstatus[`WB_MSTATUS_MIE] = m_mstatus[`WB_MSTATUS_MPIE];
            m_mstatus[`WB_MSTATUS_MPIE] = 1'b1;
        end else if (t != wb_pkg::trap_none) begin
            exp_redir = wb_pkg::redir_mtvec;
            we = 1'b0;
            m_mepc = p;
            m_mcause = cause_of(t);
            m_mstatus[`WB_MSTATUS_MPIE] = m_mstatus[`WB_MSTATUS_MIE];
            m_mstatus[`WB_MSTATUS_MIE] = 1'b0;
        end
        check_val(64'(redirect), 64'(exp_redir), $sformatf("redirect for %s", t.name()));
        case (s)
            wb_pkg::src_exe:  wd = ops[0];
            wb_pkg::src_mem:  wd = ops[1];
            wb_pkg::src_imm:  wd = ops[2];
            wb_pkg::src_snpc: wd = p + 64'd4;
            wb_pkg::src_csrrw, wb_pkg::src_csrrw_exe, wb_pkg::src_csrrwi: begin
                if (t == wb_pkg::trap_none) begin
                    we = implemented(ca);
                    wd = model_csr(ca);  // old value goes to rd
                    swap_model(ca, s == wb_pkg::src_csrrw ? m_regs[rs1_a] :
                                   s == wb_pkg::src_csrrw_exe ? ops[0] : ops[3]);
                end
            end
            default: ;
        endcase
        if (we && rd_a != '0) begin
            m_regs[rd_a] = wd;
        end
        last_rd = rd_a;
    endtask

    // a plain write, then a trap, both with commit_valid low
    task automatic invalid_commit(input logic [4:0] rd_a);
        @(negedge clk);
        quiet();
        src = wb_pkg::src_exe;
        rd = rd_a;
        exe_result = rand64();
        #2;
        check_val(64'(redirect), 64'(wb_pkg::redir_none), "redirect without commit_valid");
        @(negedge clk);
        trap = wb_pkg::trap_ecall;
        pc = rand64();
        #2;
        check_val(64'(redirect), 64'(wb_pkg::redir_none), "redirect for trap without commit");
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            passed++;
            $display("%s: pass", name);
        end else begin
            failed++;
            $display("%s: FAIL with %0d mismatches", name, errors - errs_before);
        end
    endtask

    task automatic test_reset();
        int e;
        e = errors;
        idle();
        sweep_state();
        end_test("reset state", e);
    endtask

    task automatic test_gpr_writes();
        int e;
        wb_pkg::wb_src_e kinds [4];
        e = errors;
        kinds = '{wb_pkg::src_exe, wb_pkg::src_mem, wb_pkg::src_imm, wb_pkg::src_snpc};
        for (int i = 0; i < n_gpr; i++) begin
            commit(kinds[i % 4], wb_pkg::trap_none, rand_reg(), 5'd0, 12'd0, rand64(), rand64());
        end
        commit(wb_pkg::src_exe, wb_pkg::trap_none, 5'd0, 5'd0, 12'd0, rand64(), rand64());
        invalid_commit(rand_reg());
        sweep_state();
        end_test("gpr writes", e);
    endtask

    task automatic test_csr_swaps();
        int e;
        wb_pkg::wb_src_e kinds [3];
        e = errors;
        kinds = '{wb_pkg::src_csrrw, wb_pkg::src_csrrw_exe, wb_pkg::src_csrrwi};
        for (int r = 0; r < 3; r++) begin
            for (int k = 0; k < 8; k++) begin
                commit(kinds[r], wb_pkg::trap_none, rand_reg(), rand_reg(), csr_list[k],
                       rand64(), rand64());
            end
        end
        // all ones into mie, read back through rd
        commit(wb_pkg::src_csrrw_exe, wb_pkg::trap_none, rand_reg(), 5'd0, wb_pkg::csr_mie,
               '1, rand64());
        commit(wb_pkg::src_csrrwi, wb_pkg::trap_none, rand_reg(), 5'd0, wb_pkg::csr_mie,
               64'd0, rand64());
        sweep_state();
        end_test("csr swaps", e);
    endtask

    task automatic test_traps();
        int e;
        logic [63:0] st;
        wb_pkg::trap_e kinds [7];
        e = errors;
        kinds = '{wb_pkg::trap_if_misalign, wb_pkg::trap_ecall, wb_pkg::trap_ebreak,
                  wb_pkg::trap_illegal, wb_pkg::trap_load_misalign,
                  wb_pkg::trap_store_misalign, wb_pkg::trap_timer_irq};
        commit(wb_pkg::src_csrrwi, wb_pkg::trap_none, 5'd0, 5'd0, wb_pkg::csr_mtvec,
               rand64(), rand64());
        for (int k = 0; k < 7; k++) begin
            st = rand64();
            st[`WB_MSTATUS_MIE] = k[0];  // enter with MIE both set and clear
            commit(wb_pkg::src_csrrwi, wb_pkg::trap_none, 5'd0, 5'd0, wb_pkg::csr_mstatus,
                   st, rand64());
            commit(wb_pkg::src_exe, kinds[k], rand_reg(), 5'd0, 12'd0, rand64(), rand64());
        end
        sweep_state();
        end_test("traps", e);
    endtask

    task automatic test_mret();
        int e;
        e = errors;
        commit(wb_pkg::src_csrrw_exe, wb_pkg::trap_none, 5'd0, 5'd0, wb_pkg::csr_mepc,
               rand64(), rand64());
        commit(wb_pkg::src_csrrwi, wb_pkg::trap_none, 5'd0, 5'd0, wb_pkg::csr_mstatus,
               64'd1 << `WB_MSTATUS_MPIE, rand64());
        commit(wb_pkg::src_none, wb_pkg::trap_mret, 5'd0, 5'd0, 12'd0, 64'd0, rand64());
        commit(wb_pkg::src_csrrwi, wb_pkg::trap_none, 5'd0, 5'd0, wb_pkg::csr_mstatus,
               64'd1 << `WB_MSTATUS_MIE, rand64());
        commit(wb_pkg::src_none, wb_pkg::trap_mret, 5'd0, 5'd0, 12'd0, 64'd0, rand64());
        commit(wb_pkg::src_exe, wb_pkg::trap_ecall, rand_reg(), 5'd0, 12'd0, rand64(), rand64());
        commit(wb_pkg::src_none, wb_pkg::trap_mret, 5'd0, 5'd0, 12'd0, 64'd0, rand64());
        idle();
        end_test("mret", e);
    endtask

    task automatic test_timer();
        int e;
        logic [31:0] r;
        e = errors;
        for (int i = 0; i <= n_tick; i++) begin
            r = $urandom;
            @(negedge clk);
            quiet();
            timer_irq = (i == n_tick) ? 1'b0 : (i < 2) ? ~i[0] : r[0];
            #2;
            check_outputs();  // still the sample from the last edge
            m_mip = timer_irq ? mtip : 64'd0;
        end
        idle();
        end_test("timer irq", e);
    endtask

    initial begin
        void'($urandom(30916));
        quiet();
        {rd, rs1, id_rs1, id_rs2, exe_rs1, exe_rs2, mem_rs2} = '0;
        {csr_addr, exe_csr, timer_irq} = '0;
        {exe_result, mem_data, imm, zimm, pc} = '0;
        {m_mtvec, m_mepc, m_mcause, m_mstatus, m_mie, m_mip} = '0;
        m_regs = '{default: '0};
        last_rd = '0;
        errors = 0;
        passed = 0;
        failed = 0;
        csr_list = '{wb_pkg::csr_mstatus, wb_pkg::csr_mie, wb_pkg::csr_mtvec, wb_pkg::csr_mepc,
                     wb_pkg::csr_mcause, wb_pkg::csr_mip, wb_pkg::csr_mhartid, 12'h7C0};
        wait (rst == 1'b0);
        @(posedge clk);
        test_reset();
        test_gpr_writes();
        test_csr_swaps();
        test_traps();
        test_mret();
        test_timer();
        $display("summary: %0d tests passed, %0d failed, %0d mismatches", passed, failed, errors);
        if (failed == 0 && errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        #((test_cycles + 50) * period);
        $display("timeout: the tests did not finish within %0d ns", (test_cycles + 50) * period);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/clk_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module clk_gen #(
    parameter int period = 40
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        #(4 * period) rst = 1'b0;  // drops on a falling edge
    end

    always #(period / 2) clk = ~clk;

endmodule

`default_nettype wire

// ==== verilog/wb_stage.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "wb_macros.svh"

module wb_stage (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     commit_valid,
    input  wire wb_pkg::wb_src_e    src,
    input  wire wb_pkg::trap_e      trap,
    input  wire [`WB_REG_AW-1:0]    rd,
    input  wire [`WB_REG_AW-1:0]    rs1,
    input  wire [`WB_CSR_AW-1:0]    csr_addr,
    input  wire [`WB_XLEN-1:0]      exe_result,
    input  wire [`WB_XLEN-1:0]      mem_data,
    input  wire [`WB_XLEN-1:0]      imm,
    input  wire [`WB_XLEN-1:0]      zimm,
    input  wire [`WB_XLEN-1:0]      pc,
    input  wire                     timer_irq,

    input  wire [`WB_REG_AW-1:0]    id_rs1,
    input  wire [`WB_REG_AW-1:0]    id_rs2,
    input  wire [`WB_REG_AW-1:0]    exe_rs1,
    input  wire [`WB_REG_AW-1:0]    exe_rs2,
    input  wire [`WB_REG_AW-1:0]    mem_rs2,
    input  wire [`WB_CSR_AW-1:0]    exe_csr,

    output logic [`WB_XLEN-1:0]     id_rs1_data,
    output logic [`WB_XLEN-1:0]     id_rs2_data,
    output logic [`WB_XLEN-1:0]     exe_rs1_data,
    output logic [`WB_XLEN-1:0]     exe_rs2_data,
    output logic [`WB_XLEN-1:0]     mem_rs2_data,
    output logic [`WB_XLEN-1:0]     exe_csr_data,

    output wb_pkg::redirect_e       redirect,
    output logic [`WB_XLEN-1:0]     mtvec,
    output logic [`WB_XLEN-1:0]     mepc,
    output logic [`WB_XLEN-1:0]     mstatus,
    output logic [`WB_XLEN-1:0]     mie,
    output logic [`WB_XLEN-1:0]     mip
);

    logic [`WB_REG_AW-1:0] cmt_rs1;
    logic [`WB_XLEN-1:0]   cmt_rs1_data;  // csrrw source
    logic                  rd_we;
    logic [`WB_REG_AW-1:0] rd_addr;
    logic [`WB_XLEN-1:0]   rd_data;

    csr_cmd_if csr_bus ();

    gpr_file u_gpr (
        .clk, .rst,
        .id_rs1, .id_rs2, .exe_rs1, .exe_rs2, .mem_rs2, .cmt_rs1,
        .id_rs1_data, .id_rs2_data, .exe_rs1_data, .exe_rs2_data,
        .mem_rs2_data, .cmt_rs1_data,
        .rd_we, .rd_addr, .rd_data
    );

    csr_file u_csr (
        .clk, .rst,
        .csr (csr_bus.csr),
        .exe_csr, .exe_csr_data,
        .mtvec, .mepc, .mstatus, .mie, .mip,
        .timer_irq
    );

    commit_ctrl u_commit (
        .clk, .rst,
        .commit_valid, .src, .trap, .rd, .rs1, .csr_addr,
        .exe_result, .mem_data, .imm, .zimm, .pc,
        .rs1_data (cmt_rs1_data),
        .cmt_rs1, .rd_we, .rd_addr, .rd_data, .redirect,
        .csr      (csr_bus.commit)
    );

endmodule

`default_nettype wire

// ==== verilog/commit_ctrl.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "wb_macros.svh"

module commit_ctrl (
    input  wire                     clk,
    input  wire                     rst,

    input  wire                     commit_valid,
    input  wire wb_pkg::wb_src_e    src,
    input  wire wb_pkg::trap_e      trap,
    input  wire [`WB_REG_AW-1:0]    rd,
    input  wire [`WB_REG_AW-1:0]    rs1,
    input  wire [`WB_CSR_AW-1:0]    csr_addr,
    input  wire [`WB_XLEN-1:0]      exe_result,
    input  wire [`WB_XLEN-1:0]      mem_data,
    input  wire [`WB_XLEN-1:0]      imm,
    input  wire [`WB_XLEN-1:0]      zimm,
    input  wire [`WB_XLEN-1:0]      pc,
    input  wire [`WB_XLEN-1:0]      rs1_data,

    output logic [`WB_REG_AW-1:0]   cmt_rs1,
    output logic                    rd_we,
    output logic [`WB_REG_AW-1:0]   rd_addr,
    output logic [`WB_XLEN-1:0]     rd_data,
    output wb_pkg::redirect_e       redirect,

    csr_cmd_if.commit               csr
);

    logic take_trap;  // real trap, not mret

    function automatic logic [`WB_XLEN-1:0] trap_cause(input wb_pkg::trap_e t);
        logic [`WB_XLEN-1:0] c;
        case (t)
            wb_pkg::trap_illegal:        c = 64'd2;
            wb_pkg::trap_ebreak:         c = 64'd3;
            wb_pkg::trap_load_misalign:  c = 64'd4;
            wb_pkg::trap_store_misalign: c = 64'd6;
            wb_pkg::trap_ecall:          c = 64'd11;
            wb_pkg::trap_timer_irq:      c = {1'b1, 63'd7};  // interrupt flag
            default:                     c = '0;             // if_misalign
        endcase
        return c;
    endfunction

    assign take_trap = trap != wb_pkg::trap_none && trap != wb_pkg::trap_mret;

    assign cmt_rs1   = rs1;
    assign rd_addr   = rd;

    // address, epc and cause do not depend on csr response
    assign csr.addr  = csr_addr;
    assign csr.epc   = pc;
    assign csr.cause = trap_cause(trap);

    always_comb begin
        case (src)
            wb_pkg::src_csrrw:     csr.wdata = rs1_data;
            wb_pkg::src_csrrw_exe: csr.wdata = exe_result;
            default:               csr.wdata = zimm;
        endcase
    end

    always_comb begin
        rd_we    = 1'b0;
        rd_data  = '0;
        redirect = wb_pkg::redir_none;
        csr.cmd  = wb_pkg::csr_cmd_none;
        if (commit_valid) begin
            if (trap == wb_pkg::trap_mret) begin
                csr.cmd  = wb_pkg::csr_cmd_mret;
                redirect = wb_pkg::redir_mepc;
            end else if (take_trap) begin
                csr.cmd  = wb_pkg::csr_cmd_enter_trap;
                redirect = wb_pkg::redir_mtvec;
            end

            if (!take_trap) begin
                case (src)
                    wb_pkg::src_exe: begin
                        rd_we   = 1'b1;
                        rd_data = exe_result;
                    end
                    wb_pkg::src_mem: begin
                        rd_we   = 1'b1;
                        rd_data = mem_data;
                    end
                    wb_pkg::src_imm: begin
                        rd_we   = 1'b1;
                        rd_data = imm;
                    end
                    wb_pkg::src_snpc: begin
                        rd_we   = 1'b1;
                        rd_data = pc + 64'd4;
                    end
                    wb_pkg::src_csrrw, wb_pkg::src_csrrw_exe, wb_pkg::src_csrrwi: begin
                        if (trap == wb_pkg::trap_none) begin  // mret owns the port
                            csr.cmd = wb_pkg::csr_cmd_swap;
                            rd_we   = csr.hit;
                            rd_data = csr.rdata;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    // idle cycles leave gpr, csr file and fetch untouched
    assert property (@(posedge clk) disable iff (rst)
        !commit_valid |-> (redirect == wb_pkg::redir_none && !rd_we &&
                           csr.cmd == wb_pkg::csr_cmd_none))
        else $error("commit side effect without commit_valid");

endmodule

`default_nettype wire

// ==== verilog/csr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "wb_macros.svh"

module csr_file (
    input  wire                     clk,
    input  wire                     rst,

    csr_cmd_if.csr                  csr,

    input  wire [`WB_CSR_AW-1:0]    exe_csr,
    output logic [`WB_XLEN-1:0]     exe_csr_data,

    output logic [`WB_XLEN-1:0]     mtvec,
    output logic [`WB_XLEN-1:0]     mepc,
    output logic [`WB_XLEN-1:0]     mstatus,
    output logic [`WB_XLEN-1:0]     mie,
    output logic [`WB_XLEN-1:0]     mip,

    input  wire                     timer_irq
);

    // only the machine timer bit lives in mie and mip
    localparam logic [`WB_XLEN-1:0] irq_mask = {{(`WB_XLEN-1){1'b0}}, 1'b1} << `WB_MIP_MTIP;

    logic [`WB_XLEN-1:0] mcause;

    function automatic logic csr_hit(input logic [`WB_CSR_AW-1:0] a);
        return a inside {wb_pkg::csr_mstatus, wb_pkg::csr_mie, wb_pkg::csr_mtvec,
                         wb_pkg::csr_mepc, wb_pkg::csr_mcause, wb_pkg::csr_mip,
                         wb_pkg::csr_mhartid};
    endfunction

    function automatic logic [`WB_XLEN-1:0] csr_read(input logic [`WB_CSR_AW-1:0] a);
        logic [`WB_XLEN-1:0] r;
        case (a)
            wb_pkg::csr_mstatus: r = mstatus;
            wb_pkg::csr_mie:     r = mie;
            wb_pkg::csr_mtvec:   r = mtvec;
            wb_pkg::csr_mepc:    r = mepc;
            wb_pkg::csr_mcause:  r = mcause;
            wb_pkg::csr_mip:     r = mip;
            default:             r = '0;  // mhartid and unmapped
        endcase
        return r;
    endfunction

    // commit port
    always_comb begin
        csr.hit   = csr_hit(csr.addr);
        csr.rdata = csr_read(csr.addr);
    end

    // execute stage port
    always_comb begin
        exe_csr_data = csr_read(exe_csr);
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
            mstatus <= '0;
            mie     <= '0;
            mip     <= '0;
        end else begin
            mip <= irq_mask & {`WB_XLEN{timer_irq}};  // sampled every edge

            case (csr.cmd)
                wb_pkg::csr_cmd_swap: begin
                    case (csr.addr)
                        wb_pkg::csr_mstatus: mstatus <= csr.wdata;
                        wb_pkg::csr_mie:     mie     <= csr.wdata & irq_mask;
                        wb_pkg::csr_mtvec:   mtvec   <= csr.wdata;
                        wb_pkg::csr_mepc:    mepc    <= csr.wdata;
                        wb_pkg::csr_mcause:  mcause  <= csr.wdata;
                        default: ;  // mip tracks the pin, mhartid fixed
                    endcase
                end
                wb_pkg::csr_cmd_enter_trap: begin
                    mepc   <= csr.epc;
                    mcause <= csr.cause;
                    mstatus[`WB_MSTATUS_MPIE] <= mstatus[`WB_MSTATUS_MIE];
                    mstatus[`WB_MSTATUS_MIE]  <= 1'b0;
                end
                wb_pkg::csr_cmd_mret: begin
                    mstatus[`WB_MSTATUS_MIE]  <= mstatus[`WB_MSTATUS_MPIE];
                    mstatus[`WB_MSTATUS_MPIE] <= 1'b1;
                end
                default: ;
            endcase
        end
    end

    // masking holds across any sequence of swaps and timer edges
    assert property (@(posedge clk) disable iff (rst)
        ((mie | mip) & ~irq_mask) == '0)
        else $error("reserved bits set in mie or mip");

endmodule

`default_nettype wire

// ==== verilog/gpr_file.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "wb_macros.svh"

module gpr_file (
    input  wire                     clk,
    input  wire                     rst,

    input  wire [`WB_REG_AW-1:0]    id_rs1,
    input  wire [`WB_REG_AW-1:0]    id_rs2,
    input  wire [`WB_REG_AW-1:0]    exe_rs1,
    input  wire [`WB_REG_AW-1:0]    exe_rs2,
    input  wire [`WB_REG_AW-1:0]    mem_rs2,
    input  wire [`WB_REG_AW-1:0]    cmt_rs1,

    output logic [`WB_XLEN-1:0]     id_rs1_data,
    output logic [`WB_XLEN-1:0]     id_rs2_data,
    output logic [`WB_XLEN-1:0]     exe_rs1_data,
    output logic [`WB_XLEN-1:0]     exe_rs2_data,
    output logic [`WB_XLEN-1:0]     mem_rs2_data,
    output logic [`WB_XLEN-1:0]     cmt_rs1_data,

    input  wire                     rd_we,
    input  wire [`WB_REG_AW-1:0]    rd_addr,
    input  wire [`WB_XLEN-1:0]      rd_data
);

    logic [`WB_XLEN-1:0] regs [`WB_NREG];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `WB_NREG; i++) begin
                regs[i] <= '0;
            end
        end else if (rd_we && rd_addr != '0) begin  // x0 never written
            regs[rd_addr] <= rd_data;
        end
    end

    // no bypass, reads see last edge
    assign id_rs1_data  = regs[id_rs1];
    assign id_rs2_data  = regs[id_rs2];
    assign exe_rs1_data = regs[exe_rs1];
    assign exe_rs2_data = regs[exe_rs2];
    assign mem_rs2_data = regs[mem_rs2];
    assign cmt_rs1_data = regs[cmt_rs1];

    // x0 reads zero on every port, also in the cycle after a write to it
    assert property (@(posedge clk) disable iff (rst)
        (id_rs1  != '0 || id_rs1_data  == '0) &&
        (id_rs2  != '0 || id_rs2_data  == '0) &&
        (exe_rs1 != '0 || exe_rs1_data == '0) &&
        (exe_rs2 != '0 || exe_rs2_data == '0) &&
        (mem_rs2 != '0 || mem_rs2_data == '0) &&
        (cmt_rs1 != '0 || cmt_rs1_data == '0))
        else $error("x0 read back nonzero");

endmodule

`default_nettype wire

// ==== verilog/csr_cmd_if.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "wb_macros.svh"

interface csr_cmd_if;

    wb_pkg::csr_cmd_e         cmd;
    logic [`WB_CSR_AW-1:0]    addr;
    logic [`WB_XLEN-1:0]      wdata;
    logic [`WB_XLEN-1:0]      epc;
    logic [`WB_XLEN-1:0]      cause;
    logic [`WB_XLEN-1:0]      rdata;  // old value, same cycle
    logic                     hit;

    modport commit (
        output cmd, addr, wdata, epc, cause,
        input  rdata, hit
    );

    modport csr (
        input  cmd, addr, wdata, epc, cause,
        output rdata, hit
    );

endinterface

`default_nettype wire

// ==== verilog/wb_pkg.sv ====
`default_nettype none

`include "wb_macros.svh"

package wb_pkg;

    // source of the value written to rd
    typedef enum logic [2:0] {
        src_none,
        src_exe,
        src_mem,
        src_imm,
        src_snpc,
        src_csrrw,      // new csr value from rs1
        src_csrrw_exe,  // new csr value from execute
        src_csrrwi      // new csr value from zimm
    } wb_src_e;

    // trap kind as reported down the pipe
    typedef enum logic [3:0] {
        trap_none,
        trap_if_misalign,
        trap_ecall,
        trap_mret,
        trap_ebreak,
        trap_illegal,
        trap_load_misalign,
        trap_store_misalign,
        trap_timer_irq
    } trap_e;

    typedef enum logic [1:0] {
        redir_none,
        redir_mtvec,
        redir_mepc
    } redirect_e;

    typedef enum logic [1:0] {
        csr_cmd_none,
        csr_cmd_swap,
        csr_cmd_enter_trap,
        csr_cmd_mret
    } csr_cmd_e;

    typedef enum logic [`WB_CSR_AW-1:0] {
        csr_mstatus = 12'h300,
        csr_mie     = 12'h304,
        csr_mtvec   = 12'h305,
        csr_mepc    = 12'h341,
        csr_mcause  = 12'h342,
        csr_mip     = 12'h344,
        csr_mhartid = 12'hF14
    } csr_addr_e;

endpackage

`default_nettype wire

// ==== include/wb_macros.svh ====
`ifndef WB_MACROS_SVH
`define WB_MACROS_SVH

// datapath and register file geometry
`define WB_XLEN       64
`define WB_NREG       32
`define WB_REG_AW     5

// csr address space
`define WB_CSR_AW     12

// mstatus fields
`define WB_MSTATUS_MIE    3
`define WB_MSTATUS_MPIE   7

// machine timer interrupt bit, same position in mip and mie
`define WB_MIP_MTIP       7

`endif
